//--- tcp_mem_pkg.sv
package tcp_mem_pkg;

  // packed read command as the engine emits it
  typedef logic [71:0] cmd_word_t;

  // memory side command fields
  typedef logic [63:0] mem_addr_t; // byte address
  typedef logic [31:0] mem_len_t;  // byte length

  // address field, upper half of the low 64 bits
  localparam int CMD_ADDR_LSB = 32;
  localparam int CMD_ADDR_MSB = 63;

  // length field starts at bit 0; bits 31:23 carry engine flags and are not used here
  localparam int CMD_LEN_MSB = 22;

endpackage

//--- tcp_stream_pkg.sv
package tcp_stream_pkg;

  // one 64-bit beat towards the network
  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t; // one enable per byte

  localparam int BYTES_PER_BEAT = 8;

  // beat counts for buffer credit and fill level
  typedef logic [15:0] word_count_t;

  // debug counters, wrap freely
  typedef logic [15:0] dbg_count_t;

  // command admission against buffer space
  typedef enum logic [1:0] {
    ADMIT_IDLE  = 2'd0, // ready for a new command
    ADMIT_CHECK = 2'd1, // waiting for enough credit
    ADMIT_ISSUE = 2'd2  // presenting the command to memory
  } admit_state_t;

endpackage

//--- cmd_formatter.sv
module cmd_formatter (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  tcp_mem_pkg::cmd_word_t cmd_word,
  output logic                   fmt_valid,
  input  logic                   fmt_ready,
  output tcp_mem_pkg::mem_addr_t fmt_addr,
  output tcp_mem_pkg::mem_len_t  fmt_len
);
  import tcp_mem_pkg::*;

  logic running; // set on the first edge out of reset
  logic cmd_fire;

  // accept when empty or when the held word leaves this cycle
  assign cmd_ready = running && (!fmt_valid || fmt_ready);
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      running   <= 1'b0;
      fmt_valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (cmd_fire) begin
        fmt_valid <= 1'b1; // refill, also covers drain+refill
      end else if (fmt_ready) begin
        fmt_valid <= 1'b0; // drained, nothing new
      end
    end
  end

  // unpack on accept, both fields zero extended
  always_ff @(posedge net_clk) begin
    if (cmd_fire) begin
      fmt_addr <= mem_addr_t'(cmd_word[CMD_ADDR_MSB:CMD_ADDR_LSB]); // upper 32 bits zero
      fmt_len  <= mem_len_t'(cmd_word[CMD_LEN_MSB:0]);             // 23-bit length
    end
  end

endmodule

//--- read_admit_fsm.sv
module read_admit_fsm #(
  parameter int BUFFER_DEPTH = 64
) (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  input  logic                        fmt_valid,
  output logic                        fmt_ready,
  input  tcp_mem_pkg::mem_addr_t      fmt_addr,
  input  tcp_mem_pkg::mem_len_t       fmt_len,
  output logic                        mem_cmd_valid,
  input  logic                        mem_cmd_ready,
  output tcp_mem_pkg::mem_addr_t      mem_cmd_addr,
  output tcp_mem_pkg::mem_len_t       mem_cmd_len,
  input  tcp_stream_pkg::word_count_t credit_used,
  output logic                        issue_fire,
  output tcp_stream_pkg::word_count_t issue_beats
);
  import tcp_mem_pkg::*;
  import tcp_stream_pkg::*;

  admit_state_t state;
  mem_len_t     cmd_beats;  // beats the held command returns
  mem_len_t     need_total; // promised plus this command
  logic         fits;
  logic         fmt_fire;

  assign fmt_ready     = (state == ADMIT_IDLE); // one command held at a time
  assign fmt_fire      = fmt_valid && fmt_ready;
  assign mem_cmd_valid = (state == ADMIT_ISSUE);
  assign issue_fire    = mem_cmd_valid && mem_cmd_ready;
  assign issue_beats   = word_count_t'(cmd_beats);

  // compare at full width, a length beyond the buffer just never fits
  assign need_total = mem_len_t'(credit_used) + cmd_beats;
  assign fits       = (need_total <= mem_len_t'(BUFFER_DEPTH));

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state <= ADMIT_IDLE;
    end else begin
      case (state)
        ADMIT_IDLE: begin
          if (fmt_fire) state <= ADMIT_CHECK;
        end
        ADMIT_CHECK: begin
          if (fits) state <= ADMIT_ISSUE; // credit only drains meanwhile
        end
        ADMIT_ISSUE: begin
          if (issue_fire) state <= ADMIT_IDLE;
        end
        default: state <= ADMIT_IDLE;
      endcase
    end
  end

  // latch command and round length up to whole beats
  always_ff @(posedge net_clk) begin
    if (fmt_fire) begin
      mem_cmd_addr <= fmt_addr;
      mem_cmd_len  <= fmt_len;
      cmd_beats    <= (fmt_len + mem_len_t'(BYTES_PER_BEAT - 1)) / mem_len_t'(BYTES_PER_BEAT);
    end
  end

  // memory sees a stable command until it takes it
  a_cmd_stable: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_cmd_valid && !mem_cmd_ready |=>
      mem_cmd_valid && $stable(mem_cmd_addr) && $stable(mem_cmd_len));

endmodule

//--- read_credit_counter.sv
module read_credit_counter #(
  parameter int BUFFER_DEPTH = 64
) (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  input  logic                        issue_fire,
  input  tcp_stream_pkg::word_count_t issue_beats,
  input  logic                        pop_fire,
  input  logic                        push_last_fire,
  output tcp_stream_pkg::word_count_t credit_used,
  output tcp_stream_pkg::dbg_count_t  read_cmd_count,
  output tcp_stream_pkg::dbg_count_t  read_pkg_count
);
  import tcp_stream_pkg::*;

  word_count_t credit_next;
  logic        issue_q; // events delayed one cycle for the debug counters
  logic        last_q;

  // promised beats go up on issue, down as each beat leaves on tx
  assign credit_next = credit_used + (issue_fire ? issue_beats : '0)
                     - word_count_t'(pop_fire);

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      credit_used    <= '0;
      issue_q        <= 1'b0;
      last_q         <= 1'b0;
      read_cmd_count <= '0;
      read_pkg_count <= '0;
    end else begin
      credit_used <= credit_next;
      issue_q     <= issue_fire;
      last_q      <= push_last_fire;
      if (issue_q) read_cmd_count <= read_cmd_count + 1'b1; // wraps at 16 bits
      if (last_q) read_pkg_count <= read_pkg_count + 1'b1;
    end
  end

  // admission keeps promises within the buffer
  a_credit_bound: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    credit_used <= word_count_t'(BUFFER_DEPTH));

  // every beat leaving on tx was promised by an issued command
  a_pop_promised: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    pop_fire |-> credit_used != '0);

endmodule

//--- read_data_fifo.sv
module read_data_fifo #(
  parameter int BUFFER_DEPTH = 64
) (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  input  logic                        mem_data_valid,
  output logic                        mem_data_ready,
  input  tcp_stream_pkg::data_t       mem_data,
  input  tcp_stream_pkg::keep_t       mem_keep,
  input  logic                        mem_last,
  output logic                        tx_valid,
  input  logic                        tx_ready,
  output tcp_stream_pkg::data_t       tx_data,
  output tcp_stream_pkg::keep_t       tx_keep,
  output logic                        tx_last,
  output tcp_stream_pkg::word_count_t fifo_fill,
  output logic                        pop_fire,
  output logic                        push_last_fire
);
  import tcp_stream_pkg::*;

  localparam int ADDR_W = $clog2(BUFFER_DEPTH);

  if ((BUFFER_DEPTH & (BUFFER_DEPTH - 1)) != 0 || BUFFER_DEPTH > 1024) begin : g_depth_chk
    $error("BUFFER_DEPTH must be a power of two no larger than 1024");
  end

  data_t             data_mem [BUFFER_DEPTH];
  keep_t             keep_mem [BUFFER_DEPTH];
  logic              last_mem [BUFFER_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;     // wraps with the power-of-two depth
  logic [ADDR_W-1:0] rd_ptr;
  word_count_t       fill_count; // true occupancy
  word_count_t       fill_q;     // first stage of the fill report
  logic              full;
  logic              push;

  assign full           = (fill_count == word_count_t'(BUFFER_DEPTH));
  assign mem_data_ready = !full;
  assign push           = mem_data_valid && mem_data_ready;
  assign push_last_fire = push && mem_last; // one per completed packet

  // show-ahead, head entry always on tx
  assign tx_valid = (fill_count != '0);
  assign pop_fire = tx_valid && tx_ready;
  assign tx_data  = data_mem[rd_ptr];
  assign tx_keep  = keep_mem[rd_ptr];
  assign tx_last  = last_mem[rd_ptr];

  always_ff @(posedge net_clk) begin
    if (push) begin
      data_mem[wr_ptr] <= mem_data;
      keep_mem[wr_ptr] <= mem_keep;
      last_mem[wr_ptr] <= mem_last;
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
      fill_q     <= '0;
      fifo_fill  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop_fire) rd_ptr <= rd_ptr + 1'b1;
      fill_count <= fill_count + word_count_t'(push) - word_count_t'(pop_fire);
      fill_q     <= fill_count; // fill reported two cycles late
      fifo_fill  <= fill_q;
    end
  end

  // credit admission means memory never offers data into a full buffer
  a_no_overflow: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_data_valid |-> !full);

endmodule

//--- tcp_tx_read_path.sv
module tcp_tx_read_path #(
  parameter int BUFFER_DEPTH = 64
) (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  tcp_mem_pkg::cmd_word_t      cmd_word,
  output logic                        mem_cmd_valid,
  input  logic                        mem_cmd_ready,
  output tcp_mem_pkg::mem_addr_t      mem_cmd_addr,
  output tcp_mem_pkg::mem_len_t       mem_cmd_len,
  input  logic                        mem_data_valid,
  output logic                        mem_data_ready,
  input  tcp_stream_pkg::data_t       mem_data,
  input  tcp_stream_pkg::keep_t       mem_keep,
  input  logic                        mem_last,
  output logic                        tx_valid,
  input  logic                        tx_ready,
  output tcp_stream_pkg::data_t       tx_data,
  output tcp_stream_pkg::keep_t       tx_keep,
  output logic                        tx_last,
  output tcp_stream_pkg::word_count_t fifo_fill,
  output tcp_stream_pkg::dbg_count_t  read_cmd_count,
  output tcp_stream_pkg::dbg_count_t  read_pkg_count
);
  import tcp_mem_pkg::*;
  import tcp_stream_pkg::*;

  logic        fmt_valid; // formatter to admission
  logic        fmt_ready;
  mem_addr_t   fmt_addr;
  mem_len_t    fmt_len;
  word_count_t credit_used; // promised beats back to admission
  logic        issue_fire;
  word_count_t issue_beats;
  logic        pop_fire;  // buffer events to the counters
  logic        push_last_fire;

  cmd_formatter u_cmd_formatter (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_word    (cmd_word),
    .fmt_valid   (fmt_valid),
    .fmt_ready   (fmt_ready),
    .fmt_addr    (fmt_addr),
    .fmt_len     (fmt_len)
  );

  read_admit_fsm #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_read_admit_fsm (
    .net_clk       (net_clk),
    .net_aresetn   (net_aresetn),
    .fmt_valid     (fmt_valid),
    .fmt_ready     (fmt_ready),
    .fmt_addr      (fmt_addr),
    .fmt_len       (fmt_len),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_addr  (mem_cmd_addr),
    .mem_cmd_len   (mem_cmd_len),
    .credit_used   (credit_used),
    .issue_fire    (issue_fire),
    .issue_beats   (issue_beats)
  );

  read_credit_counter #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_read_credit_counter (
    .net_clk        (net_clk),
    .net_aresetn    (net_aresetn),
    .issue_fire     (issue_fire),
    .issue_beats    (issue_beats),
    .pop_fire       (pop_fire),
    .push_last_fire (push_last_fire),
    .credit_used    (credit_used),
    .read_cmd_count (read_cmd_count),
    .read_pkg_count (read_pkg_count)
  );

  read_data_fifo #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_read_data_fifo (
    .net_clk        (net_clk),
    .net_aresetn    (net_aresetn),
    .mem_data_valid (mem_data_valid),
    .mem_data_ready (mem_data_ready),
    .mem_data       (mem_data),
    .mem_keep       (mem_keep),
    .mem_last       (mem_last),
    .tx_valid       (tx_valid),
    .tx_ready       (tx_ready),
    .tx_data        (tx_data),
    .tx_keep        (tx_keep),
    .tx_last        (tx_last),
    .fifo_fill      (fifo_fill),
    .pop_fire       (pop_fire),
    .push_last_fire (push_last_fire)
  );

endmodule

//--- tb_checker.sv
module tb_checker #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic        net_clk,
  input  logic        net_aresetn,
  input  logic        cmd_valid,
  input  logic        cmd_ready,
  input  logic [71:0] cmd_word,
  input  logic        mem_cmd_valid,
  input  logic        mem_cmd_ready,
  input  logic [63:0] mem_cmd_addr,
  input  logic [31:0] mem_cmd_len,
  input  logic        mem_data_valid,
  input  logic        mem_data_ready,
  input  logic        tx_valid,
  input  logic        tx_ready,
  input  logic [63:0] tx_data,
  input  logic [7:0]  tx_keep,
  input  logic        tx_last,
  input  logic [15:0] fifo_fill,
  input  logic [15:0] read_cmd_count,
  input  logic [15:0] read_pkg_count,
  input  logic        end_check,
  output int          error_count,
  output int          check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [95:0] exp_cmd_q[$];  // {addr, len} per accepted word
  logic [72:0] exp_beat_q[$]; // {last, keep, data} per expected tx beat
  int          errors = 0;
  int          checks = 0;
  int          promised = 0;     // beats issued and not yet sent on tx
  int          cmd_accepted = 0;
  int          last_seen = 0;
  int          occ = 0;          // beats held in the buffer
  int          occ_d1 = 0;       // occupancy one edge back
  int          occ_d2 = 0;       // two edges back, what fifo_fill shows
  logic        after_reset = 1'b0; // first cycle out of reset

  assign error_count = errors;
  assign check_count = checks;

  // address from 63:32 and length from 22:0 with zero extension
  function automatic logic [95:0] expected_cmd(logic [71:0] word);
    return {32'h0, word[63:32], 9'h0, word[22:0]};
  endfunction

  // last beat keeps len mod 8 bytes or all 8 when the remainder is zero
  function automatic logic [7:0] keep_for_len(logic [31:0] len);
    return (len[2:0] == 3'd0) ? 8'hff : 8'hff >> (4'd8 - len[2:0]);
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  // compare mid-cycle on settled values
  always @(negedge net_clk) begin
    logic [95:0] e;
    logic [72:0] b;
    int          n;
    if (!net_aresetn || after_reset) begin
      check_value("reset cmd_ready", 0, cmd_ready);
      check_value("reset mem_cmd_valid", 0, mem_cmd_valid);
      check_value("reset tx_valid", 0, tx_valid);
      check_value("reset read_cmd_count", 0, read_cmd_count);
      check_value("reset read_pkg_count", 0, read_pkg_count);
    end
    after_reset = !net_aresetn;
    if (!net_aresetn) begin
      occ    = 0;
      occ_d1 = 0;
      occ_d2 = 0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        exp_cmd_q.push_back(expected_cmd(cmd_word)); // issue order = accept order
        cmd_accepted++;
      end
      if (mem_cmd_valid && mem_cmd_ready) begin
        if (exp_cmd_q.size() == 0) begin
          report_problem("a memory command was issued with no command pending");
        end else begin
          e = exp_cmd_q.pop_front();
          check_value("unpack mem_cmd_addr", e[95:32], mem_cmd_addr);
          check_value("unpack mem_cmd_len", e[31:0], mem_cmd_len);
        end
        n = int'((mem_cmd_len + 32'd7) / 32'd8); // whole beats
        promised += n;
        for (int i = 0; i < n; i++) begin
          exp_beat_q.push_back({i == n - 1, (i == n - 1) ? keep_for_len(mem_cmd_len) : 8'hff,
                                mem_cmd_addr + 64'(i)});
        end
      end
      if (mem_data_valid && !mem_data_ready) begin
        report_problem("the buffer refused memory data that admission had made room for");
      end
      if (tx_valid && tx_ready) begin
        if (exp_beat_q.size() == 0) begin
          report_problem("a tx beat was sent with no data expected");
        end else begin
          b = exp_beat_q.pop_front();
          check_value("data tx_data", b[63:0], tx_data);
          check_value("data tx_keep", 64'(b[71:64]), tx_keep);
          check_value("data tx_last", 64'(b[72]), tx_last);
        end
        promised--;
        if (tx_last) last_seen++;
      end
      if (promised > BUFFER_DEPTH) begin
        report_problem("more beats were promised than the buffer can hold");
      end
      check_value("fill fifo_fill", 64'(occ_d2), fifo_fill); // trails by two edges
      occ_d2 = occ_d1;
      occ_d1 = occ;
      occ    = occ + int'(mem_data_valid && mem_data_ready) - int'(tx_valid && tx_ready);
      if (end_check) begin
        check_value("counters read_cmd_count", 64'(cmd_accepted), read_cmd_count);
        check_value("counters read_pkg_count", 64'(last_seen), read_pkg_count);
        check_value("counters fifo_fill", 0, fifo_fill);
        if (exp_cmd_q.size() != 0 || exp_beat_q.size() != 0) begin
          report_problem("commands or data beats were still outstanding at the end");
        end
      end
    end
  end

endmodule

//--- tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH      = 16;
  localparam int NUM_CMDS   = 40;
  localparam int WAIT_LIMIT = 2000; // cycles allowed per wait

  logic        net_clk;
  logic        net_aresetn;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [71:0] cmd_word;
  logic        mem_cmd_valid;
  logic        mem_cmd_ready;
  logic [63:0] mem_cmd_addr;
  logic [31:0] mem_cmd_len;
  logic        mem_data_valid;
  logic        mem_data_ready;
  logic [63:0] mem_data;
  logic [7:0]  mem_keep;
  logic        mem_last;
  logic        tx_valid;
  logic        tx_ready;
  logic [63:0] tx_data;
  logic [7:0]  tx_keep;
  logic        tx_last;
  logic [15:0] fifo_fill;
  logic [15:0] read_cmd_count;
  logic [15:0] read_pkg_count;
  logic        end_check;       // final counter compare in the checker
  int          error_count;
  int          check_count;
  int          seed;
  int          issued = 0;      // commands taken by the memory model
  int          ready_cycle = 0; // cycles since reset release
  int          beat_idx = 0;
  logic        took;
  logic [63:0] rsp_addr[$];     // accepted memory commands, oldest first
  logic [31:0] rsp_len[$];

  tcp_tx_read_path #(.BUFFER_DEPTH(DEPTH)) UUT (.*);

  tb_checker #(.BUFFER_DEPTH(DEPTH)) u_checker (.*);

  initial begin
    net_clk = 1'b0;
    forever #2 net_clk = ~net_clk;
  end

  task automatic abort_run(string why);
    $display("ERROR: timeout, %s", why);
    $display("closing: %0d errors in %0d checks, run stopped early", error_count, check_count);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge net_clk);
      #1;
    end
  endtask

  // random flags in 71:64 and 31:23 must not leak into the fields
  function automatic logic [71:0] random_cmd();
    logic [71:0] w;
    w[71:64] = 8'($random(seed));
    w[63:32] = $random(seed);
    w[31:23] = 9'($random(seed));
    w[22:0]  = 23'(1 + $unsigned($random(seed)) % 100); // 1 to 100 bytes
    return w;
  endfunction

  task automatic send_cmd(logic [71:0] word);
    int t;
    t = 0;
    cmd_valid = 1'b1;
    cmd_word  = word;
    @(negedge net_clk);
    while (!cmd_ready) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("cmd_ready never came high for a waiting command");
      @(negedge net_clk);
    end
    @(posedge net_clk); // transfer on this edge
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    @(negedge net_clk);
    #1; // after the responder's negedge update
    while (issued != NUM_CMDS || rsp_len.size() != 0 || tx_valid) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("traffic did not drain, commands or data are stuck");
      @(negedge net_clk);
      #1;
    end
    @(posedge net_clk);
    #1;
  endtask

  // memory model, returns each command's beats in order
  initial begin
    forever begin
      @(negedge net_clk);
      took = mem_data_valid && mem_data_ready;
      if (net_aresetn && mem_cmd_valid && mem_cmd_ready) begin
        rsp_addr.push_back(mem_cmd_addr);
        rsp_len.push_back(mem_cmd_len);
        issued++;
      end
      @(posedge net_clk);
      #1;
      if (took && mem_last) begin
        void'(rsp_addr.pop_front()); // packet done
        void'(rsp_len.pop_front());
        beat_idx = 0;
      end else if (took) begin
        beat_idx++;
      end
      if (rsp_len.size() != 0 && ((mem_data_valid && !took) || ($random(seed) & 3) != 0)) begin
        mem_data_valid = 1'b1;
        mem_data       = rsp_addr[0] + 64'(beat_idx); // address plus beat index
        mem_last       = (beat_idx == int'((rsp_len[0] + 7) / 8) - 1);
        mem_keep       = (mem_last && rsp_len[0][2:0] != 0) ? 8'hff >> (8 - rsp_len[0][2:0])
                                                             : 8'hff;
      end else begin
        mem_data_valid = 1'b0;
      end
    end
  end

  // tx random at first, then held low, then open for good
  initial begin
    forever begin
      @(posedge net_clk);
      #1;
      mem_cmd_ready = ($random(seed) & 3) != 0;
      if (net_aresetn) ready_cycle++;
      if (ready_cycle < 60) tx_ready = ($random(seed) & 1) != 0;
      else tx_ready = (ready_cycle >= 260);
    end
  end

  initial begin
    seed           = 39;
    net_aresetn    = 1'b0;
    cmd_valid      = 1'b0;
    cmd_word       = '0;
    mem_cmd_ready  = 1'b0;
    mem_data_valid = 1'b0;
    mem_data       = '0;
    mem_keep       = '0;
    mem_last       = 1'b0;
    tx_ready       = 1'b0;
    end_check      = 1'b0;
    repeat (2) @(posedge net_clk);
    #1;
    net_aresetn = 1'b1;
    for (int i = 0; i < NUM_CMDS; i++) begin
      send_cmd(random_cmd());
      idle_cycles($unsigned($random(seed)) % 3); // short random gaps
    end
    wait_drained();
    idle_cycles(4);
    end_check = 1'b1;
    idle_cycles(1);
    end_check = 1'b0;
    $display("closing: %0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
tcp_mem_pkg.sv
tcp_stream_pkg.sv
cmd_formatter.sv
read_admit_fsm.sv
read_credit_counter.sv
read_data_fifo.sv
tcp_tx_read_path.sv
tb_checker.sv
tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
  echo "run_sim: passed" ||
  { echo "run_sim: failed"; exit 1; }
